// File: flist.f
+incdir+verilog
verilog/mem_op_pkg.sv
verilog/mem_trap_pkg.sv
verilog/mem_interface.sv
verilog/data_mem.sv
verilog/load_align.sv
verilog/mem_stage.sv
sim/mem_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory stage testbench with Verilator and runs it
# the exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module mem_stage_tb -o mem_stage_sim &&
./obj_dir/mem_stage_sim ||
{ echo "memory stage simulation did not pass"; exit 1; }

// File: sim/mem_stage_tb.sv
// memory stage testbench, a shadow word array predicts every flag and every load result
// random traffic stays in words 0..15, which are filled by word stores before any load

`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_stage_tb;
    import mem_op_pkg::*;
    import mem_trap_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int LO_W       = `MEM_IDX_MSB + 1;  // address bits the memory decodes

    // operations per test, every issued cycle counts, idle ones too
    localparam int N_IDLE  = 4;
    localparam int N_FILL  = 16;
    localparam int N_PAIRS = 8;   // store/load pairs
    localparam int N_LANES = 12;
    localparam int N_EXT   = 26;
    localparam int N_MIS   = 11;
    localparam int N_RAND  = 400;
    localparam int N_DRAIN = 4;
    localparam int N_OPS   = N_IDLE + N_FILL + 2 * N_PAIRS + N_LANES + N_EXT + N_MIS
                           + N_RAND + N_DRAIN;

    // what one issued operation should produce
    typedef struct packed {
        logic                 m_op;
        logic                 trap;
        mem_cause_e           cause;
        logic                 lvalid;
        logic [`MEM_XLEN-1:0] ldata;
    } expect_t;

    logic                 clk = 1'b0;
    logic                 nrst;
    mem_op_e              mem_op;
    logic [`MEM_XLEN-1:0] op_a;
    logic [`MEM_XLEN-1:0] op_b;
    logic [`MEM_XLEN-1:0] s_imm;
    logic                 m_op;
    logic                 trap_valid;
    mem_cause_e           trap_cause;
    logic [`MEM_XLEN-1:0] load_data;
    logic                 load_valid;

    logic [`MEM_XLEN-1:0] shadow [`MEM_WORDS];  // reference copy of the data memory
    expect_t              inflight [$];          // newest first, three deep
    logic [31:0]          rng_state = 32'h0f1d_08d2;

    // expected outputs, updated on the falling edge
    logic                 exp_m_op;
    logic                 exp_trap;
    mem_cause_e           exp_cause;
    logic                 exp_lvalid;
    logic [`MEM_XLEN-1:0] exp_ldata;

    mem_stage dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .mem_op     (mem_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .s_imm      (s_imm),
        .m_op       (m_op),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // odd multiplier, so every address bit changes the word
    function automatic logic [`MEM_XLEN-1:0] fill_pattern(input logic [`MEM_XLEN-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [LO_W-1:0] word_offset(input int w, input int off);
        return LO_W'(4 * w + off);
    endfunction

    function automatic mem_op_e op_from_index(input int sel);
        case (sel)
            0:       return MEM_SW;
            1:       return MEM_SH;
            2:       return MEM_SB;
            3:       return MEM_LW;
            4:       return MEM_LH;
            5:       return MEM_LHU;
            6:       return MEM_LB;
            7:       return MEM_LBU;
            default: return MEM_NONE;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("FAIL %s expected 0x%08h actual 0x%08h", name, expv, actv);
        $display("Verification failed");
        $fatal(1, "%s differs from the shadow model", name);
    endtask

    // applies one op to the shadow array and returns what the DUT must show
    task automatic model_access(input mem_op_e op, input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] s, output expect_t rec);
        int          size;
        int          off;
        int          idx;
        logic        store;
        logic        sext;
        logic [31:0] addr;
        logic [31:0] mask;
        logic [31:0] val;
        store = (op == MEM_SW) || (op == MEM_SH) || (op == MEM_SB);
        sext  = (op == MEM_LH) || (op == MEM_LB);
        case (op)
            MEM_SW, MEM_LW:          size = 4;
            MEM_SH, MEM_LH, MEM_LHU: size = 2;
            MEM_SB, MEM_LB, MEM_LBU: size = 1;
            default:                 size = 0;
        endcase
        addr = store ? (s + a) : (b + a);
        idx  = int'(addr[`MEM_IDX_MSB:`MEM_IDX_LSB]);  // wraps on the upper bits
        off  = int'(addr[1:0]);
        mask = (32'd1 << (8 * size)) - 32'd1;          // all ones for a word
        rec  = '0;
        if (size != 0) begin
            rec.m_op = 1'b1;
            if (off % size != 0) begin
                rec.trap  = 1'b1;
                rec.cause = store ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
            end else if (store) begin
                for (int j = off; j < off + size; j++) begin
                    shadow[idx][8*j +: 8] = b[8*j +: 8];  // lane j keeps lane j of the data
                end
            end else begin
                val = (shadow[idx] >> (8 * off)) & mask;
                if (sext && val[8*size-1]) begin
                    val = val | ~mask;
                end
                rec.lvalid = 1'b1;
                rec.ldata  = val;
            end
        end
    endtask

    // drive one op on the falling edge and move the expected pipeline along
    task automatic issue(input mem_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] s);
        expect_t rec;
        @(negedge clk);
        mem_op = op;
        op_a   = a;
        op_b   = b;
        s_imm  = s;
        exp_m_op   = inflight[1].m_op;    // issued two cycles back
        exp_trap   = inflight[1].trap;
        exp_cause  = inflight[1].cause;
        exp_lvalid = inflight[2].lvalid;  // three cycles back
        exp_ldata  = inflight[2].ldata;
        model_access(op, a, b, s, rec);
        void'(inflight.pop_back());
        inflight.push_front(rec);
    endtask

    // random base, immediate picked so the low address bits hit target
    task automatic access(input mem_op_e op, input logic [LO_W-1:0] target,
                          input logic [31:0] data);
        logic [31:0] base;
        logic [31:0] upper;
        logic [31:0] junk;
        logic [31:0] imm;
        base  = next_rand();
        upper = next_rand();
        junk  = next_rand();
        imm   = {upper[`MEM_XLEN-LO_W-1:0], target} - base;
        if (op[3]) begin
            issue(op, base, data, imm);  // store, address from s_imm
        end else begin
            issue(op, base, imm, junk);  // load, address from op_b
        end
    endtask

    a_m_op: assert property (@(posedge clk) disable iff (!nrst) m_op == exp_m_op)
        else report_mismatch("m_op", 32'($sampled(exp_m_op)), 32'($sampled(m_op)));

    a_trap_valid: assert property (@(posedge clk) disable iff (!nrst) trap_valid == exp_trap)
        else report_mismatch("trap_valid", 32'($sampled(exp_trap)), 32'($sampled(trap_valid)));

    a_trap_cause: assert property (@(posedge clk) disable iff (!nrst) trap_cause == exp_cause)
        else report_mismatch("trap_cause", 32'($sampled(exp_cause)), 32'($sampled(trap_cause)));

    a_load_valid: assert property (@(posedge clk) disable iff (!nrst) load_valid == exp_lvalid)
        else report_mismatch("load_valid", 32'($sampled(exp_lvalid)), 32'($sampled(load_valid)));

    a_load_data: assert property (@(posedge clk) disable iff (!nrst)
        load_valid |-> load_data == exp_ldata)
        else report_mismatch("load_data", $sampled(exp_ldata), $sampled(load_data));

    initial begin
        #(CLK_PERIOD * (N_OPS + 20));
        $display("timeout, the stimulus did not complete in %0d ns", CLK_PERIOD * (N_OPS + 20));
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        nrst       = 1'b0;
        mem_op     = MEM_NONE;
        op_a       = '0;
        op_b       = '0;
        s_imm      = '0;
        exp_m_op   = 1'b0;
        exp_trap   = 1'b0;
        exp_cause  = CAUSE_NONE;
        exp_lvalid = 1'b0;
        exp_ldata  = '0;
        for (int i = 0; i < 3; i++) begin
            inflight.push_back('0);  // pipeline holds idle ops out of reset
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        // idle cycles, every flag stays low
        repeat (N_IDLE) issue(MEM_NONE, '0, '0, '0);

        for (int w = 0; w < N_FILL; w++) begin
            access(MEM_SW, word_offset(w, 0), fill_pattern(32'(4 * w)));
        end

        // store then load of the same word, back to back
        for (int i = 0; i < N_PAIRS; i++) begin
            r = next_rand();
            access(MEM_SW, word_offset(int'(r[3:0]), 0), next_rand());
            access(MEM_LW, word_offset(int'(r[3:0]), 0), '0);
        end

        // partial stores into word 3, whole word read back each time
        for (int off = 0; off < 4; off++) begin
            access(MEM_SB, word_offset(3, off), next_rand());
            access(MEM_LW, word_offset(3, 0), '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(MEM_SH, word_offset(3, off), next_rand());
            access(MEM_LW, word_offset(3, 0), '0);
        end

        // negative and positive bytes and halves for the extension
        access(MEM_SW, word_offset(5, 0), 32'h807f_ff01);
        access(MEM_SW, word_offset(6, 0), 32'h7f80_017e);
        for (int w = 5; w < 7; w++) begin
            for (int off = 0; off < 4; off++) begin
                access(MEM_LB, word_offset(w, off), '0);
                access(MEM_LBU, word_offset(w, off), '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                access(MEM_LH, word_offset(w, off), '0);
                access(MEM_LHU, word_offset(w, off), '0);
            end
        end

        // misaligned accesses on word 7, cancelled and trapped
        access(MEM_SH, word_offset(7, 1), 32'hdead_beef);
        access(MEM_SH, word_offset(7, 3), 32'hdead_beef);
        for (int off = 1; off < 4; off++) begin
            access(MEM_SW, word_offset(7, off), 32'hffff_ffff);
        end
        access(MEM_LH, word_offset(7, 1), '0);
        access(MEM_LH, word_offset(7, 3), '0);
        for (int off = 1; off < 4; off++) begin
            access(MEM_LW, word_offset(7, off), '0);
        end
        access(MEM_LW, word_offset(7, 0), '0);  // still the fill value

        // mixed traffic, one op per cycle, any byte offset
        for (int i = 0; i < N_RAND; i++) begin
            r = next_rand();
            access(op_from_index(int'(r[7:0]) % 9), LO_W'(r[13:8]), next_rand());
        end

        // let the last loads come out
        repeat (N_DRAIN) issue(MEM_NONE, '0, '0, '0);
        @(posedge clk);
        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog/data_mem.sv
// single port data memory, byte-masked synchronous write, registered read
// array contents are undefined after reset, write before reading

`timescale 1ns/1ps
`include "mem_consts.svh"

module data_mem (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [`MEM_XLEN-1:0]  addr,
    input  logic [`MEM_XLEN-1:0]  wdata,
    input  logic [`MEM_LANES-1:0] be,
    input  logic                  gwe,
    input  logic                  rd,
    output logic [`MEM_XLEN-1:0]  rdata
);
    localparam int IDX_W = `MEM_IDX_MSB - `MEM_IDX_LSB + 1;

    logic [`MEM_XLEN-1:0] mem_q [`MEM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic [`MEM_XLEN-1:0] cur_word;  // stored word at idx
    logic [`MEM_XLEN-1:0] fwd_word;  // stored word with this cycle's write merged in

    // upper address bits dropped, addresses wrap
    assign idx      = addr[`MEM_IDX_MSB:`MEM_IDX_LSB];
    assign cur_word = mem_q[idx];

    // per-lane merge for a same-cycle write and read
    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            if (gwe && be[i]) begin
                fwd_word[8*i +: 8] = wdata[8*i +: 8];
            end else begin
                fwd_word[8*i +: 8] = cur_word[8*i +: 8];
            end
        end
    end

    // write only the enabled lanes
    always_ff @(posedge clk) begin
        if (gwe) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                if (be[i]) begin
                    mem_q[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read register, holds its value between reads
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rdata <= '0;
        end else if (rd) begin
            rdata <= fwd_word;
        end
    end

endmodule

// File: verilog/load_align.sv
// stage 7 load formatting, runs in step with the one cycle memory read
// word loads pass through, byte/half loads are shifted down and extended

`timescale 1ns/1ps
`include "mem_consts.svh"

module load_align (
    input  logic                 clk,
    input  logic                 nrst,
    input  mem_op_pkg::mem_op_e  mem_op6,
    input  logic [1:0]           baddr6,   // addr6 bits 1:0
    input  logic                 rd6,
    input  logic [`MEM_XLEN-1:0] rdata7,
    output logic [`MEM_XLEN-1:0] load_data7,
    output logic                 load_valid7
);
    import mem_op_pkg::*;

    mem_op_e    mem_op7;
    logic [1:0] baddr7;
    logic       rd7;
    mem_width_e width7;
    logic       sign7;     // op bit 0, signed load
    logic [7:0] lane_b7;   // selected byte
    logic [15:0] lane_h7;  // selected half

    // follows the memory read latency
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            mem_op7 <= MEM_NONE;
            rd7     <= 1'b0;
        end else begin
            mem_op7 <= mem_op6;
            rd7     <= rd6;
        end
    end

    always_ff @(posedge clk) begin
        baddr7 <= baddr6;
    end

    assign width7      = mem_width_e'(mem_op7[2:1]);
    assign sign7       = mem_op7[0];
    assign load_valid7 = rd7;

    assign lane_b7 = rdata7[{baddr7, 3'b000} +: 8];
    assign lane_h7 = rdata7[{baddr7[1], 4'b0000} +: 16];  // bit 0 is 0 on legal halves

    always_comb begin
        unique case (width7)
            W_BYTE:  load_data7 = {{(`MEM_XLEN-8){sign7 & lane_b7[7]}}, lane_b7};
            W_HALF:  load_data7 = {{(`MEM_XLEN-16){sign7 & lane_h7[15]}}, lane_h7};
            default: load_data7 = rdata7;  // word, or don't care without rd7
        endcase
    end

    // misaligned halves are cancelled in stage 5
    a_half_aligned: assert property (@(posedge clk) disable iff (!nrst)
        (rd7 && width7 == W_HALF) |-> !baddr7[0]);

    // a read strobe only ever comes from a load
    a_rd_is_load: assert property (@(posedge clk) disable iff (!nrst)
        rd7 |-> (!mem_op7[3] && mem_op7 != MEM_NONE));

endmodule

// File: verilog/mem_consts.svh
// sizes for the memory stage, the data memory is word organised
// word index bits must match MEM_WORDS, upper address bits are ignored

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// data and address width
`define MEM_XLEN 32

// depth of the data memory in 32-bit words
`define MEM_WORDS 1024

// address bits that select a word, anything above wraps
`define MEM_IDX_MSB 11
`define MEM_IDX_LSB 2

// byte lanes per word
`define MEM_LANES 4

`endif

// File: verilog/mem_interface.sv
// stage 5/6 of the memory pipeline, no stall and no handshake
// a misaligned access is cancelled and only reported through the trap outputs

`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_interface (
    input  logic                     clk,
    input  logic                     nrst,
    input  mem_op_pkg::mem_op_e      mem_op4,
    input  logic [`MEM_XLEN-1:0]     op_a4,   // base address
    input  logic [`MEM_XLEN-1:0]     op_b4,   // store data, or I-imm for loads
    input  logic [`MEM_XLEN-1:0]     s_imm4,  // S-imm for stores
    output logic [`MEM_XLEN-1:0]     addr6,
    output logic [`MEM_XLEN-1:0]     wdata6,
    output logic [`MEM_LANES-1:0]    be6,
    output logic                     gwe6,
    output logic                     rd6,
    output logic                     m_op6,
    output mem_op_pkg::mem_op_e      mem_op6,
    output logic                     trap_valid6,
    output mem_trap_pkg::mem_cause_e trap_cause6
);
    import mem_op_pkg::*;
    import mem_trap_pkg::*;

    // stage 5 registers
    mem_op_e              mem_op5;
    logic [`MEM_XLEN-1:0] op_a5;
    logic [`MEM_XLEN-1:0] op_b5;
    logic [`MEM_XLEN-1:0] s_imm5;

    // stage 5 decode
    mem_width_e            width5;
    logic                  is_store5;
    logic                  m_op5;
    logic [`MEM_XLEN-1:0]  addr5;
    logic                  misaligned5;
    logic                  gwe5;
    logic                  rd5;
    logic [`MEM_LANES-1:0] be5;
    logic [`MEM_LANES-1:0] lanes5;  // lanes touched, before gating
    mem_cause_e            cause5;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            mem_op5 <= MEM_NONE;
        end else begin
            mem_op5 <= mem_op4;
        end
    end

    // operands are payload, only meaningful with a valid op
    always_ff @(posedge clk) begin
        op_a5  <= op_a4;
        op_b5  <= op_b4;
        s_imm5 <= s_imm4;
    end

    assign is_store5 = mem_op5[3];
    assign width5    = mem_width_e'(mem_op5[2:1]);
    assign m_op5     = (mem_op5 != MEM_NONE);

    // stores add S-imm, loads add I-imm held in op_b
    assign addr5 = is_store5 ? (s_imm5 + op_a5) : (op_b5 + op_a5);

    always_comb begin
        misaligned5 = 1'b0;
        lanes5      = '0;
        unique case (width5)
            W_BYTE: begin
                lanes5 = 4'b0001 << addr5[1:0];  // one lane at the byte offset
            end
            W_HALF: begin
                misaligned5 = addr5[0];
                lanes5      = addr5[1] ? 4'b1100 : 4'b0011;
            end
            W_WORD: begin
                misaligned5 = addr5[1] | addr5[0];
                lanes5      = 4'b1111;
            end
            default: ;  // MEM_NONE, nothing touched
        endcase
    end

    // a misaligned access is dropped before it reaches the memory
    assign gwe5 = m_op5 & is_store5 & ~misaligned5;
    assign rd5  = m_op5 & ~is_store5 & ~misaligned5;
    assign be5  = gwe5 ? lanes5 : '0;

    always_comb begin
        if (!m_op5 || !misaligned5) begin
            cause5 = CAUSE_NONE;
        end else if (is_store5) begin
            cause5 = CAUSE_STORE_MISALIGNED;
        end else begin
            cause5 = CAUSE_LOAD_MISALIGNED;
        end
    end

    // stage 6 control
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            gwe6        <= 1'b0;
            rd6         <= 1'b0;
            be6         <= '0;
            m_op6       <= 1'b0;
            mem_op6     <= MEM_NONE;
            trap_valid6 <= 1'b0;
            trap_cause6 <= CAUSE_NONE;
        end else begin
            gwe6        <= gwe5;
            rd6         <= rd5;
            be6         <= be5;
            m_op6       <= m_op5;
            mem_op6     <= mem_op5;
            trap_valid6 <= m_op5 & misaligned5;
            trap_cause6 <= cause5;
        end
    end

    // stage 6 address and data, qualified by the strobes
    always_ff @(posedge clk) begin
        addr6  <= addr5;
        wdata6 <= op_b5;  // store data goes out unshifted
    end

    // single port, never both strobes
    a_strobe_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(gwe6 && rd6));

    // byte enables only travel with a write
    a_be_with_gwe: assert property (@(posedge clk) disable iff (!nrst)
        (|be6) |-> gwe6);

    // a trapped access never reaches the memory
    a_trap_cancels: assert property (@(posedge clk) disable iff (!nrst)
        trap_valid6 |-> (!gwe6 && !rd6));

endmodule

// File: verilog/mem_op_pkg.sv
// memory operation encoding shared by the pipeline and the load aligner
// bit 3 store, bits 2:1 width, bit 0 signed (always set on stores)

package mem_op_pkg;

    // memory operation as delivered by stage 4
    //   0000      no memory access
    //   1111 SW   1011 SH   1101 SB
    //   0111 LW   0011 LH   0010 LHU   0101 LB   0100 LBU
    typedef enum logic [3:0] {
        MEM_NONE = 4'b0000,
        MEM_SW   = 4'b1111,
        MEM_SH   = 4'b1011,
        MEM_SB   = 4'b1101,
        MEM_LW   = 4'b0111,
        MEM_LH   = 4'b0011,
        MEM_LHU  = 4'b0010,
        MEM_LB   = 4'b0101,
        MEM_LBU  = 4'b0100
    } mem_op_e;

    // width field, taken from mem_op bits 2:1
    // 00 only appears with MEM_NONE and has no name
    typedef enum logic [1:0] {
        W_HALF = 2'b01,
        W_BYTE = 2'b10,
        W_WORD = 2'b11
    } mem_width_e;

endpackage

// File: verilog/mem_stage.sv
// memory stage top: address/strobe pipeline, data memory and load aligner
// fixed latency, results two edges after the inputs are sampled, no stalls

`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_stage (
    input  logic                     clk,
    input  logic                     nrst,
    input  mem_op_pkg::mem_op_e      mem_op,
    input  logic [`MEM_XLEN-1:0]     op_a,
    input  logic [`MEM_XLEN-1:0]     op_b,
    input  logic [`MEM_XLEN-1:0]     s_imm,
    output logic                     m_op,
    output logic                     trap_valid,
    output mem_trap_pkg::mem_cause_e trap_cause,
    output logic [`MEM_XLEN-1:0]     load_data,
    output logic                     load_valid
);
    import mem_op_pkg::*;

    // stage 6 memory controls
    logic [`MEM_XLEN-1:0]  addr6;
    logic [`MEM_XLEN-1:0]  wdata6;
    logic [`MEM_LANES-1:0] be6;
    logic                  gwe6;
    logic                  rd6;
    mem_op_e               mem_op6;  // op handed on to the aligner

    // stage 7 raw read word
    logic [`MEM_XLEN-1:0]  rdata7;

    mem_interface mem_if_i (
        .clk         (clk),
        .nrst        (nrst),
        .mem_op4     (mem_op),
        .op_a4       (op_a),
        .op_b4       (op_b),
        .s_imm4      (s_imm),
        .addr6       (addr6),
        .wdata6      (wdata6),
        .be6         (be6),
        .gwe6        (gwe6),
        .rd6         (rd6),
        .m_op6       (m_op),
        .mem_op6     (mem_op6),
        .trap_valid6 (trap_valid),
        .trap_cause6 (trap_cause)
    );

    data_mem dmem_i (
        .clk   (clk),
        .nrst  (nrst),
        .addr  (addr6),
        .wdata (wdata6),
        .be    (be6),
        .gwe   (gwe6),
        .rd    (rd6),
        .rdata (rdata7)
    );

    load_align ld_align_i (
        .clk         (clk),
        .nrst        (nrst),
        .mem_op6     (mem_op6),
        .baddr6      (addr6[1:0]),  // byte offset within the word
        .rd6         (rd6),
        .rdata7      (rdata7),
        .load_data7  (load_data),
        .load_valid7 (load_valid)
    );

endmodule

// File: verilog/mem_trap_pkg.sv
// trap causes raised by the memory stage, values follow the RISC-V mcause codes
// atomics would share the store cause, but they are not handled here

package mem_trap_pkg;

    // exception cause for memory traps
    typedef enum logic [3:0] {
        CAUSE_NONE             = 4'd0,
        CAUSE_LOAD_MISALIGNED  = 4'd4, // load address misaligned
        CAUSE_STORE_MISALIGNED = 4'd6  // store/amo address misaligned
    } mem_cause_e;

endpackage
